// File: dv/glbTb.sv
/*
 * Global buffer testbench
 * Table-driven configuration and stream traffic on both channels,
 * checked against a FIFO model per channel
 */
`timescale 1ns/1ps
`include "glb_params.svh"

module glbTb
    import glbDataPkg::*;
    import glbCfgPkg::*;
();

    localparam int NumRows = 5;

    typedef struct packed {
        glbChId_t     ch;
        glbBankMask_t mask;
        glbAddr_t     addrMax;
        logic [7:0]   nWords;
        logic [7:0]   stall;
        logic         launch;
    } stimRow_t;

    logic                          clk;
    logic                          rst_n;
    logic                          cfgVld;
    glbChId_t                      cfgCh;
    glbBankMask_t                  cfgMask;
    glbAddr_t                      cfgAddrMax;
    logic                          cfgRdy;
    logic     [`GLB_NUM_CH-1:0]    wrVld;
    glbWord_t [`GLB_NUM_CH-1:0]    wrDat;
    logic     [`GLB_NUM_CH-1:0]    wrRdy;
    logic     [`GLB_NUM_CH-1:0]    wrFull;
    glbAddr_t [`GLB_NUM_CH-1:0]    wrReqNum;
    logic     [`GLB_NUM_CH-1:0]    rdVld;
    glbWord_t [`GLB_NUM_CH-1:0]    rdDat;
    logic     [`GLB_NUM_CH-1:0]    rdRdy;
    logic     [`GLB_NUM_CH-1:0]    rdEmpty;
    glbAddr_t [`GLB_NUM_CH-1:0]    rdReqNum;

    // ========================================
    // Stimulus table
    // ========================================
    // ch, bank mask, address max, words, read stall pattern, run traffic
    // Stall pattern 8'hFF keeps the channel's reads blocked for the row
    stimRow_t rows [NumRows] = '{
        '{1'b0, 8'h03, 8'd40,  8'd40, 8'h26, 1'b0},
        '{1'b1, 8'h30, 8'd255, 8'd36, 8'h49, 1'b1},
        // Capacity 20 plus the two words the read port takes
        '{1'b0, 8'h0C, 8'd20,  8'd22, 8'hFF, 1'b1},
        '{1'b1, 8'hC0, 8'd24,  8'd10, 8'hFF, 1'b1},
        '{1'b0, 8'h03, 8'd48,  8'd6,  8'h0F, 1'b1}
    };
    string rowName [NumRows] = '{"spanCh0", "dualCh1", "fillCh0", "holdCh1", "reCfgCh0"};

    glbWord_t    model [`GLB_NUM_CH][$];
    int          pending [`GLB_NUM_CH];
    glbWord_t    curWord [`GLB_NUM_CH];
    logic [7:0]  stallPat [`GLB_NUM_CH];
    glbAddr_t    capTb [`GLB_NUM_CH];
    logic [31:0] rngState = 32'd13;
    int          errors = 0;
    int          checks = 0;
    int          cycle = 0;
    string       curName = "reset";

    glbTop dut (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Smaller of the address max and the words of the claimed banks
    function automatic glbAddr_t expectedCapacity(glbBankMask_t mask, glbAddr_t addrMax);
        int span;
        span = $countones(mask) * `GLB_BANK_DEPTH;
        return (addrMax < span) ? addrMax : glbAddr_t'(span);
    endfunction

    task automatic checkEq(input string what, input logic [31:0] expVal,
                           input logic [31:0] actVal);
        checks++;
        if (expVal !== actVal) begin
            errors++;
            $display("Mismatch %s/%s: expected %0h, actual %0h", curName, what, expVal, actVal);
        end
    endtask

    // ========================================
    // Configuration
    // ========================================
    task automatic applyConfig(input int r);
        int       c;
        int       lowCycles;
        glbAddr_t cap;
        c   = rows[r].ch;
        cap = expectedCapacity(rows[r].mask, rows[r].addrMax);
        @(negedge clk);
        cfgVld     = 1'b1;
        cfgCh      = rows[r].ch;
        cfgMask    = rows[r].mask;
        cfgAddrMax = rows[r].addrMax;
        while (!cfgRdy) @(negedge clk);
        @(negedge clk);
        cfgVld    = 1'b0;
        lowCycles = 0;
        while (!cfgRdy) begin
            lowCycles++;
            @(negedge clk);
        end
        // Transfer cycle, scan and commit
        checkEq("cfgCycles", `GLB_NUM_BANK + 2, lowCycles + 1);
        checkEq("cfgEmpty", 1, rdEmpty[c]);
        checkEq("cfgWrReqNum", cap, wrReqNum[c]);
        checkEq("cfgRdReqNum", 0, rdReqNum[c]);
        // Words already handed to the read port survive the commit
        while (model[c].size() > 2) void'(model[c].pop_back());
        capTb[c]    = cap;
        pending[c]  = rows[r].nWords;
        stallPat[c] = rows[r].stall;
        rngState    = xorshift(rngState);
        curWord[c]  = rngState;
    endtask

    // ========================================
    // Stream traffic on all channels
    // ========================================
    task automatic runTraffic();
        logic [`GLB_NUM_CH-1:0] prevVld;
        logic [`GLB_NUM_CH-1:0] prevRdy;
        glbWord_t               prevDat [`GLB_NUM_CH];
        glbWord_t               expWord;
        logic                   work;
        prevVld = '0;
        prevRdy = '1;
        do begin
            @(negedge clk);
            cycle++;
            for (int c = 0; c < `GLB_NUM_CH; c++) begin
                // Stalled output must not move
                if (prevVld[c] && !prevRdy[c]) begin
                    checkEq($sformatf("ch%0d holdVld", c), 1, rdVld[c]);
                    checkEq($sformatf("ch%0d holdDat", c), prevDat[c], rdDat[c]);
                end
                wrVld[c] = (pending[c] != 0);
                wrDat[c] = curWord[c];
                rdRdy[c] = !stallPat[c][cycle % 8];
                if (wrVld[c] && wrRdy[c]) begin
                    model[c].push_back(curWord[c]);
                    pending[c]--;
                    rngState   = xorshift(rngState);
                    curWord[c] = rngState;
                end
                if (rdVld[c] && rdRdy[c]) begin
                    if (model[c].size() == 0) begin
                        errors++;
                        $display("%s: channel %0d returned a word that was never written",
                                 curName, c);
                    end else begin
                        expWord = model[c].pop_front();
                        checkEq($sformatf("ch%0d data", c), expWord, rdDat[c]);
                    end
                end
                prevVld[c] = rdVld[c];
                prevRdy[c] = rdRdy[c];
                prevDat[c] = rdDat[c];
            end
            work = 1'b0;
            for (int c = 0; c < `GLB_NUM_CH; c++) begin
                if (pending[c] != 0 || (stallPat[c] != 8'hFF && model[c].size() != 0)) begin
                    work = 1'b1;
                end
            end
        end while (work);
        @(negedge clk);
        wrVld = '0;
        rdRdy = '0;
    endtask

    // Blocked channel: two words sit in the read port, the rest count
    task automatic checkHeld(input int c);
        int stored;
        stored = model[c].size() - ((model[c].size() < 2) ? model[c].size() : 2);
        checkEq($sformatf("ch%0d rdReqNum", c), stored, rdReqNum[c]);
        checkEq($sformatf("ch%0d wrReqNum", c), capTb[c] - stored, wrReqNum[c]);
        checkEq($sformatf("ch%0d wrFull", c), stored == capTb[c], wrFull[c]);
        checkEq($sformatf("ch%0d wrRdy", c), stored != capTb[c], wrRdy[c]);
        checkEq($sformatf("ch%0d rdEmpty", c), stored == 0, rdEmpty[c]);
    endtask

    // ========================================
    // Main sequence
    // ========================================
    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        cfgVld     = 1'b0;
        cfgCh      = '0;
        cfgMask    = '0;
        cfgAddrMax = '0;
        wrVld      = '0;
        wrDat      = '0;
        rdRdy      = '0;
        for (int c = 0; c < `GLB_NUM_CH; c++) begin
            pending[c]  = 0;
            curWord[c]  = '0;
            stallPat[c] = 8'h00;
            capTb[c]    = '0;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        checkEq("cfgRdy", 1, cfgRdy);
        // No banks owned, so every channel is both full and empty
        for (int c = 0; c < `GLB_NUM_CH; c++) begin
            checkEq($sformatf("ch%0d wrFull", c), 1, wrFull[c]);
            checkEq($sformatf("ch%0d rdEmpty", c), 1, rdEmpty[c]);
            checkEq($sformatf("ch%0d wrRdy", c), 0, wrRdy[c]);
            checkEq($sformatf("ch%0d rdVld", c), 0, rdVld[c]);
        end

        for (int r = 0; r < NumRows; r++) begin
            curName = rowName[r];
            applyConfig(r);
            if (rows[r].launch) begin
                runTraffic();
                for (int c = 0; c < `GLB_NUM_CH; c++) begin
                    if (stallPat[c] == 8'hFF) checkHeld(c);
                end
            end
        end

        // Read back everything still stored
        curName = "drain";
        for (int c = 0; c < `GLB_NUM_CH; c++) begin
            stallPat[c] = 8'h00;
        end
        runTraffic();
        repeat (3) begin
            @(negedge clk);
            for (int c = 0; c < `GLB_NUM_CH; c++) begin
                checkEq($sformatf("ch%0d finalVld", c), 0, rdVld[c]);
                checkEq($sformatf("ch%0d finalEmpty", c), 1, rdEmpty[c]);
            end
        end

        $display("Run finished: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // ========================================
    // Watchdog
    // ========================================
    initial begin : watchdog
        int limitCycles;
        limitCycles = 500 + NumRows * (`GLB_NUM_BANK + 2);
        for (int r = 0; r < NumRows; r++) begin
            limitCycles += 20 * rows[r].nWords;
        end
        repeat (limitCycles) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", limitCycles);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: hdl/glbBankArray.sv
/*
 * Bank array
 * Holds every bank and routes each channel's write and read to the
 * owned bank whose relative index matches the requested one
 */
`timescale 1ns/1ps
`include "glb_params.svh"

module glbBankArray
    import glbDataPkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    glbMapIf.bank  map,
    glbBankIf.bank bank
);

    glbWord_t                 mem   [`GLB_NUM_BANK][`GLB_BANK_DEPTH];
    logic [`GLB_NUM_BANK-1:0] wrHit;
    logic [`GLB_NUM_BANK-1:0] rdHit [`GLB_NUM_CH];

    // ========================================
    // Bank selection
    // ========================================
    always_comb begin
        // Each bank listens to its owner only
        for (int b = 0; b < `GLB_NUM_BANK; b++) begin
            wrHit[b] = map.owned[b] && bank.wrEn[map.owner[b]] &&
                       (map.relIdx[b] == bank.wrRel[map.owner[b]]);
        end
        for (int c = 0; c < `GLB_NUM_CH; c++) begin
            for (int b = 0; b < `GLB_NUM_BANK; b++) begin
                rdHit[c][b] = map.owned[b] && (map.owner[b] == c) && bank.rdEn[c] &&
                              (map.relIdx[b] == bank.rdRel[c]);
            end
        end
    end

    // ========================================
    // Storage
    // ========================================
    always_ff @(posedge clk) begin
        for (int b = 0; b < `GLB_NUM_BANK; b++) begin
            if (wrHit[b]) begin
                mem[b][bank.wrOff[map.owner[b]]] <= bank.wrDat[map.owner[b]];
            end
        end
    end

    // Read data returns one cycle after the issue
    always_ff @(posedge clk) begin
        for (int c = 0; c < `GLB_NUM_CH; c++) begin
            for (int b = 0; b < `GLB_NUM_BANK; b++) begin
                if (rdHit[c][b]) begin
                    bank.rdDat[c] <= mem[b][bank.rdOff[c]];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int c = 0; c < `GLB_NUM_CH; c++) begin
                bank.rdVld[c] <= 1'b0;
            end
        end else begin
            for (int c = 0; c < `GLB_NUM_CH; c++) begin
                bank.rdVld[c] <= |rdHit[c];
            end
        end
    end

    // Relative indices from the decode are unique per channel
    for (genvar c = 0; c < `GLB_NUM_CH; c++) begin : genChk
        oneBankPerRead: assert property (@(posedge clk) disable iff (!rst_n)
            $onehot0(rdHit[c]));
    end

endmodule

// File: hdl/glbCfgDecode.sv
/*
 * Configuration decode
 * Accepts a channel configuration, walks the banks one per cycle to
 * rebuild ownership and relative indices, then commits the capacity
 */
`timescale 1ns/1ps
`include "glb_params.svh"

module glbCfgDecode
    import glbDataPkg::*;
    import glbCfgPkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         cfgVld,
    input  glbChId_t     cfgCh,
    input  glbBankMask_t cfgMask,
    input  glbAddr_t     cfgAddrMax,
    output logic         cfgRdy,
    glbMapIf.decode      map
);

    glbCfgState_t state;
    glbBankIdx_t  scanIdx;
    glbChId_t     cfgChQ;
    glbBankMask_t cfgMaskQ;
    glbAddr_t     cfgAddrMaxQ;
    glbAddr_t     bankSpan;
    logic         cfgAcc;

    assign cfgRdy   = (state == Idle);
    assign cfgAcc   = cfgVld && cfgRdy;
    // Words covered by the banks claimed so far
    assign bankSpan = glbAddr_t'(map.numBanks[cfgChQ] * `GLB_BANK_DEPTH);

    // ========================================
    // FSM
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= Idle;
            scanIdx <= '0;
        end else begin
            case (state)
                Idle: begin
                    if (cfgAcc) begin
                        state   <= Scan;
                        scanIdx <= '0;
                    end
                end
                Scan: begin
                    if (scanIdx == glbBankIdx_t'(`GLB_NUM_BANK - 1)) begin
                        state <= Commit;
                    end else begin
                        scanIdx <= scanIdx + 1'b1;
                    end
                end
                default: state <= Idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cfgAcc) begin
            cfgChQ      <= cfgCh;
            cfgMaskQ    <= cfgMask;
            cfgAddrMaxQ <= cfgAddrMax;
        end
    end

    // ========================================
    // Ownership map
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            map.owned <= '0;
            for (int b = 0; b < `GLB_NUM_BANK; b++) begin
                map.owner[b]  <= '0;
                map.relIdx[b] <= '0;
            end
            for (int c = 0; c < `GLB_NUM_CH; c++) begin
                map.capacity[c] <= '0;
                map.numBanks[c] <= '0;
            end
        end else if (cfgAcc) begin
            map.numBanks[cfgCh] <= '0;
        end else if (state == Scan) begin
            if (cfgMaskQ[scanIdx]) begin
                // Claimed banks are numbered in ascending bank order
                map.owned[scanIdx]   <= 1'b1;
                map.owner[scanIdx]   <= cfgChQ;
                map.relIdx[scanIdx]  <= glbBankIdx_t'(map.numBanks[cfgChQ]);
                map.numBanks[cfgChQ] <= map.numBanks[cfgChQ] + 1'b1;
            end else if (map.owned[scanIdx] && map.owner[scanIdx] == cfgChQ) begin
                map.owned[scanIdx] <= 1'b0;
            end
        end else if (state == Commit) begin
            map.capacity[cfgChQ] <= (cfgAddrMaxQ < bankSpan) ? cfgAddrMaxQ : bankSpan;
        end
    end

    always_comb begin
        for (int c = 0; c < `GLB_NUM_CH; c++) begin
            map.busy[c]  = (state != Idle) && (cfgChQ == glbChId_t'(c));
            map.clear[c] = (state == Commit) && (cfgChQ == glbChId_t'(c));
        end
    end

    // Next transfer only after the full scan and commit
    cfgSpacing: assert property (@(posedge clk) disable iff (!rst_n)
        cfgAcc |=> !cfgRdy [*(`GLB_NUM_BANK + 1)] ##1 cfgRdy);

endmodule

// File: hdl/glbCfgPkg.sv
/*
 * Global buffer configuration types
 * Channel numbers, bank masks and the decode FSM states
 */
`include "glb_params.svh"

package glbCfgPkg;

    typedef logic [$clog2(`GLB_NUM_CH)-1:0] glbChId_t;

    // One bit per bank
    typedef logic [`GLB_NUM_BANK-1:0] glbBankMask_t;

    // Decode FSM
    typedef enum logic [1:0] {
        Idle,
        Scan,
        Commit
    } glbCfgState_t;

endpackage

// File: hdl/glbChannelCtrl.sv
/*
 * Channel controller
 * Write and read pointers, fill count, status flags, and the split
 * of each pointer into a relative bank index and a bank offset
 */
`timescale 1ns/1ps
`include "glb_params.svh"

module glbChannelCtrl
    import glbDataPkg::*;
    import glbCfgPkg::*;
#(
    parameter glbChId_t CH = '0
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     wrVld,
    input  glbWord_t wrDat,
    output logic     wrRdy,
    output logic     wrFull,
    output logic     rdEmpty,
    output glbAddr_t wrReqNum,
    output glbAddr_t rdReqNum,
    input  logic     rdCredit,
    glbMapIf.chan    map,
    glbBankIf.chan   bank
);

    localparam int OffW = $bits(glbOffset_t);
    localparam int RelW = $bits(glbBankIdx_t);

    glbAddr_t wrPtr;
    glbAddr_t rdPtr;
    glbAddr_t count;
    glbAddr_t ptrDist;
    logic     wrAcc;
    logic     rdIss;

    // Pointers wrap at the channel capacity
    function automatic glbAddr_t stepPtr(glbAddr_t ptr, glbAddr_t cap);
        glbAddr_t nxt;
        nxt = ptr + 1'b1;
        return (nxt == cap) ? '0 : nxt;
    endfunction

    // ========================================
    // Flags and request numbers
    // ========================================
    assign wrFull   = (count == map.capacity[CH]);
    assign rdEmpty  = (count == '0);
    assign wrReqNum = map.capacity[CH] - count;
    assign rdReqNum = count;

    assign wrRdy = !wrFull && !map.busy[CH];
    assign wrAcc = wrVld && wrRdy;
    // Issue only when the read port has room for the returning word
    assign rdIss = !rdEmpty && !map.busy[CH] && rdCredit;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else if (map.clear[CH]) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (wrAcc) begin
                wrPtr <= stepPtr(wrPtr, map.capacity[CH]);
            end
            if (rdIss) begin
                rdPtr <= stepPtr(rdPtr, map.capacity[CH]);
            end
            case ({wrAcc, rdIss})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // ========================================
    // Bank access
    // ========================================
    assign bank.wrEn[CH]  = wrAcc;
    assign bank.wrRel[CH] = wrPtr[OffW +: RelW];
    assign bank.wrOff[CH] = wrPtr[OffW-1:0];
    assign bank.wrDat[CH] = wrDat;
    assign bank.rdEn[CH]  = rdIss;
    assign bank.rdRel[CH] = rdPtr[OffW +: RelW];
    assign bank.rdOff[CH] = rdPtr[OffW-1:0];

    // Words between the pointers, modulo the capacity
    assign ptrDist = (wrPtr >= rdPtr) ? glbAddr_t'(wrPtr - rdPtr)
                                      : glbAddr_t'(wrPtr + map.capacity[CH] - rdPtr);

    // Capacity only changes together with the clear of the count
    countInRange: assert property (@(posedge clk) disable iff (!rst_n)
        count <= map.capacity[CH]);

    // Pointer distance agrees with the count, a full channel wraps to zero
    ptrMatchesCount: assert property (@(posedge clk) disable iff (!rst_n)
        ptrDist == ((count == map.capacity[CH]) ? glbAddr_t'(0) : count));

endmodule

// File: hdl/glbDataPkg.sv
/*
 * Global buffer data types
 * Words, channel-local addresses and counts, bank offsets and
 * bank indices
 */
`include "glb_params.svh"

package glbDataPkg;

    // One stored word
    typedef logic [`GLB_DATA_W-1:0] glbWord_t;

    // Channel-local word address, also used for word counts
    typedef logic [`GLB_ADDR_W-1:0] glbAddr_t;

    // Word position inside one bank
    typedef logic [$clog2(`GLB_BANK_DEPTH)-1:0] glbOffset_t;

    // Absolute bank number or index of a bank within its channel
    typedef logic [$clog2(`GLB_NUM_BANK)-1:0] glbBankIdx_t;

endpackage

// File: hdl/glbIf.sv
/*
 * Global buffer internal interfaces
 * Bank ownership map from the decode, and per-channel bank access
 * between the channel controllers, the bank array and the read ports
 */
`timescale 1ns/1ps
`include "glb_params.svh"

// ========================================
// Bank ownership map
// ========================================
interface glbMapIf
    import glbDataPkg::*;
    import glbCfgPkg::*;
();
    // Per bank
    glbBankMask_t owned;
    glbChId_t     owner    [`GLB_NUM_BANK];
    glbBankIdx_t  relIdx   [`GLB_NUM_BANK];

    // Per channel
    glbAddr_t     capacity [`GLB_NUM_CH];
    glbAddr_t     numBanks [`GLB_NUM_CH];
    logic         busy     [`GLB_NUM_CH];
    logic         clear    [`GLB_NUM_CH];

    modport decode (output owned, owner, relIdx, capacity, numBanks, busy, clear);
    modport chan   (input capacity, busy, clear);
    modport bank   (input owned, owner, relIdx);
endinterface

// ========================================
// Per-channel bank access
// ========================================
interface glbBankIf
    import glbDataPkg::*;
();
    logic        wrEn  [`GLB_NUM_CH];
    glbBankIdx_t wrRel [`GLB_NUM_CH];
    glbOffset_t  wrOff [`GLB_NUM_CH];
    glbWord_t    wrDat [`GLB_NUM_CH];
    logic        rdEn  [`GLB_NUM_CH];
    glbBankIdx_t rdRel [`GLB_NUM_CH];
    glbOffset_t  rdOff [`GLB_NUM_CH];
    glbWord_t    rdDat [`GLB_NUM_CH];
    logic        rdVld [`GLB_NUM_CH];

    modport chan (output wrEn, wrRel, wrOff, wrDat, rdEn, rdRel, rdOff);
    modport bank (input wrEn, wrRel, wrOff, wrDat, rdEn, rdRel, rdOff,
                  output rdDat, rdVld);
    modport sink (input rdDat, rdVld, rdEn);
endinterface

// File: hdl/glbReadPort.sv
/*
 * Read port
 * Two-entry ordered buffer between the bank array and the read
 * stream, with a credit for the channel's next read issue
 */
`timescale 1ns/1ps
`include "glb_params.svh"

module glbReadPort
    import glbDataPkg::*;
#(
    parameter int unsigned CH = 0
) (
    input  logic     clk,
    input  logic     rst_n,
    glbBankIf.sink   bank,
    output logic     rdVld,
    output glbWord_t rdDat,
    input  logic     rdRdy,
    output logic     rdCredit
);

    glbWord_t   ent [2];
    logic       wrSel;
    logic       rdSel;
    logic [1:0] held;
    logic [1:0] inFlight;
    logic       push;
    logic       pop;

    assign push  = bank.rdVld[CH];
    assign pop   = rdVld && rdRdy;
    assign rdVld = (held != 2'd0);
    assign rdDat = ent[rdSel];

    // Room for one more word once held and in-flight words are counted
    assign rdCredit = ({1'b0, held} + {1'b0, inFlight}) < 3'd2;

    always_ff @(posedge clk) begin
        if (push) begin
            ent[wrSel] <= bank.rdDat[CH];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wrSel    <= 1'b0;
            rdSel    <= 1'b0;
            held     <= '0;
            inFlight <= '0;
        end else begin
            if (push) begin
                wrSel <= !wrSel;
            end
            if (pop) begin
                rdSel <= !rdSel;
            end
            case ({push, pop})
                2'b10:   held <= held + 1'b1;
                2'b01:   held <= held - 1'b1;
                default: held <= held;
            endcase
            // Issued by the channel but not yet returned by a bank
            case ({bank.rdEn[CH], push})
                2'b10:   inFlight <= inFlight + 1'b1;
                2'b01:   inFlight <= inFlight - 1'b1;
                default: inFlight <= inFlight;
            endcase
        end
    end

    noOverflow: assert property (@(posedge clk) disable iff (!rst_n)
        push && !pop |-> held != 2'd2);

endmodule

// File: hdl/glbTop.sv
/*
 * Banked global buffer
 * Shared banks assigned to channels by configuration, each channel
 * working as a FIFO with its own write and read stream
 */
`timescale 1ns/1ps
`include "glb_params.svh"

module glbTop
    import glbDataPkg::*;
    import glbCfgPkg::*;
(
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          cfgVld,
    input  glbChId_t                      cfgCh,
    input  glbBankMask_t                  cfgMask,
    input  glbAddr_t                      cfgAddrMax,
    output logic                          cfgRdy,
    input  logic     [`GLB_NUM_CH-1:0]    wrVld,
    input  glbWord_t [`GLB_NUM_CH-1:0]    wrDat,
    output logic     [`GLB_NUM_CH-1:0]    wrRdy,
    output logic     [`GLB_NUM_CH-1:0]    wrFull,
    output glbAddr_t [`GLB_NUM_CH-1:0]    wrReqNum,
    output logic     [`GLB_NUM_CH-1:0]    rdVld,
    output glbWord_t [`GLB_NUM_CH-1:0]    rdDat,
    input  logic     [`GLB_NUM_CH-1:0]    rdRdy,
    output logic     [`GLB_NUM_CH-1:0]    rdEmpty,
    output glbAddr_t [`GLB_NUM_CH-1:0]    rdReqNum
);

    glbMapIf  mapIf ();
    glbBankIf bankIf ();

    // ========================================
    // Configuration and storage
    // ========================================
    glbCfgDecode uDecode (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfgVld     (cfgVld),
        .cfgCh      (cfgCh),
        .cfgMask    (cfgMask),
        .cfgAddrMax (cfgAddrMax),
        .cfgRdy     (cfgRdy),
        .map        (mapIf)
    );

    glbBankArray uBanks (
        .clk   (clk),
        .rst_n (rst_n),
        .map   (mapIf),
        .bank  (bankIf)
    );

    // ========================================
    // Channels
    // ========================================
    for (genvar c = 0; c < `GLB_NUM_CH; c++) begin : genCh
        logic credit;

        glbChannelCtrl #(.CH(glbChId_t'(c))) uCtrl (
            .clk      (clk),
            .rst_n    (rst_n),
            .wrVld    (wrVld[c]),
            .wrDat    (wrDat[c]),
            .wrRdy    (wrRdy[c]),
            .wrFull   (wrFull[c]),
            .rdEmpty  (rdEmpty[c]),
            .wrReqNum (wrReqNum[c]),
            .rdReqNum (rdReqNum[c]),
            .rdCredit (credit),
            .map      (mapIf),
            .bank     (bankIf)
        );

        glbReadPort #(.CH(c)) uRead (
            .clk      (clk),
            .rst_n    (rst_n),
            .bank     (bankIf),
            .rdVld    (rdVld[c]),
            .rdDat    (rdDat[c]),
            .rdRdy    (rdRdy[c]),
            .rdCredit (credit)
        );
    end

endmodule

// File: include/glb_params.svh
/*
 * Global buffer sizing
 * Bank count, bank depth, word width, channel count and the
 * width of channel-local addresses and word counts
 */
`ifndef GLB_PARAMS_SVH
`define GLB_PARAMS_SVH

// ========================================
// Bank array
// ========================================
// Number of single-clock banks
`define GLB_NUM_BANK   8
// Words per bank, a power of two
`define GLB_BANK_DEPTH 16
`define GLB_DATA_W     32

// ========================================
// Channels
// ========================================
`define GLB_NUM_CH     2
// Must hold GLB_NUM_BANK * GLB_BANK_DEPTH
`define GLB_ADDR_W     8

`endif

// File: tb.f
+incdir+include
hdl/glbDataPkg.sv
hdl/glbCfgPkg.sv
hdl/glbIf.sv
hdl/glbCfgDecode.sv
hdl/glbChannelCtrl.sv
hdl/glbBankArray.sv
hdl/glbReadPort.sv
hdl/glbTop.sv
dv/glbTb.sv
